/* dv/memCases.txt */
// Columns in hex: op, address, block count, data seed
// op 0 posts a write, op 1 posts a read, op 2 waits for all posted tasks to finish
0 1000 1 10000000
0 1020 2 11000000
0 1040 3 12000000
0 1060 4 13000000
0 1080 1 14000000
0 10A0 2 15000000
0 10C0 3 16000000
0 10E0 4 17000000
0 1100 2 18000000
2 0 0 0
0 200 1 AB000000
2 0 0 0
1 200 1 0
2 0 0 0
0 400 4 C0000000
2 0 0 0
1 400 4 0
2 0 0 0
0 800 4 D0000000
0 C00 2 E0000000
1 1060 4 0
2 0 0 0
1 10E0 4 0
0 200 2 F0000000
2 0 0 0
1 200 2 0
1 800 4 0
1 C00 2 0
1 1100 2 0
2 0 0 0

/* flist.f */
logic/memCtrlPkg.sv
logic/taskQueue.sv
logic/seqControl.sv
logic/writeSerializer.sv
logic/readAssembler.sv
logic/memController.sv
dv/clockGen.sv
dv/appModel.sv
dv/scoreboard.sv
dv/memControllerProps.sv
dv/tbMemController.sv

/* Bender.yml */
package:
  name: memController

sources:
  - logic/memCtrlPkg.sv
  - logic/taskQueue.sv
  - logic/seqControl.sv
  - logic/writeSerializer.sv
  - logic/readAssembler.sv
  - logic/memController.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/appModel.sv
      - dv/scoreboard.sv
      - dv/memControllerProps.sv
      - dv/tbMemController.sv

/* dv/tbMemController.sv */
`timescale 1ns/1ps

module tbMemController
    import memCtrlPkg::*;
;

    logic MIGUICLK, resetn;
    logic rdReq, rdAck, rdDone, wrReq, wrAck, wrDone;
    logic [addrW-1:0] rdAddr, rdDoneAddr, wrAddr, appAddr;
    logic [blockCountW-1:0] rdBlocks, wrBlocks;
    logic [taskWords-1:0][wordW-1:0] rdData, wrData;
    logic appEn, appRdy, appWdfWren, appWdfEnd, appWdfRdy, appRdDataValid;
    logic [2:0] appCmd;
    logic [appDataW-1:0] appWdfData, appRdData;
    logic initCalibComplete;

    logic [31:0] cases [0:255];
    int caseCount;
    int rdPosted = 0;
    int wrPosted = 0;
    int rdSeen = 0;
    int wrSeen = 0;
    int totalErrors;

    clockGen clkGen (.*);
    memController dut (.*);
    appModel model (.*);
    scoreboard sb (.*);

    always @(negedge MIGUICLK) begin
        if (rdDone) rdSeen++;
        if (wrDone) wrSeen++;
    end

    //////////////////////////////
    // Four-phase requests
    task automatic postWrite(input logic [addrW-1:0] addr, input logic [blockCountW-1:0] blocks,
                             input logic [31:0] seed);
        @(posedge MIGUICLK);
        #1;
        wrAddr   = addr;
        wrBlocks = blocks;
        for (int k = 0; k < taskWords; k++) begin
            wrData[k] = seed + 32'(k);
        end
        wrReq = 1'b1;
        do @(posedge MIGUICLK); while (!wrAck);
        #1 wrReq = 1'b0;
        do @(posedge MIGUICLK); while (wrAck);
        wrPosted++;
    endtask

    task automatic postRead(input logic [addrW-1:0] addr, input logic [blockCountW-1:0] blocks);
        @(posedge MIGUICLK);
        #1;
        rdAddr   = addr;
        rdBlocks = blocks;
        rdReq    = 1'b1;
        do @(posedge MIGUICLK); while (!rdAck);
        #1 rdReq = 1'b0;
        do @(posedge MIGUICLK); while (rdAck);
        rdPosted++;
    endtask

    task automatic drainAll();
        while (rdSeen != rdPosted || wrSeen != wrPosted) begin
            @(posedge MIGUICLK);
        end
    endtask

    //////////////////////////////
    initial begin
        rdReq    = 1'b0;
        rdAddr   = '0;
        rdBlocks = '0;
        wrReq    = 1'b0;
        wrAddr   = '0;
        wrBlocks = '0;
        wrData   = '0;
        void'($urandom(32'h211));
        for (int i = 0; i < 256; i++) begin
            cases[i] = 32'hFFFF_FFFF;
        end
        $readmemh("dv/memCases.txt", cases);
        caseCount = 0;
        while (caseCount < 64 && cases[4 * caseCount] != 32'hFFFF_FFFF) begin
            caseCount++;
        end
        @(posedge resetn);
        fork
            begin
                for (int i = 0; i < caseCount; i++) begin
                    case (cases[4 * i])
                        32'd0: postWrite(cases[4 * i + 1][addrW-1:0],
                                         cases[4 * i + 2][blockCountW-1:0], cases[4 * i + 3]);
                        32'd1: postRead(cases[4 * i + 1][addrW-1:0],
                                        cases[4 * i + 2][blockCountW-1:0]);
                        default: drainAll();
                    endcase
                end
                drainAll();
                repeat (10) @(posedge MIGUICLK);
            end
            begin
                repeat (caseCount * 2000) @(posedge MIGUICLK);
                $display("Timeout: tests did not finish within %0d cycles", caseCount * 2000);
                $display("FAIL: see errors above");
                $finish;
            end
        join_any
        sb.checkPending();
        totalErrors = sb.dataErrors + sb.flowErrors + dut.props.assertFails;
        $display("Errors: data %0d, flow %0d, assertion %0d",
                 sb.dataErrors, sb.flowErrors, dut.props.assertFails);
        if (totalErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* dv/memControllerProps.sv */
`timescale 1ns/1ps

module memControllerProps
    import memCtrlPkg::*;
(
    input logic             MIGUICLK,
    input logic             resetn,
    input logic             appEn,
    input logic [2:0]       appCmd,
    input logic [addrW-1:0] appAddr,
    input logic             appRdy,
    input logic             appWdfWren,
    input logic             appWdfEnd,
    input logic             initCalibComplete
);

    int assertFails = 0;

    cmdHold: assert property (@(posedge MIGUICLK) disable iff (!resetn)
        appEn && !appRdy |=> appEn && $stable(appCmd) && $stable(appAddr))
        else begin
            $error("App command changed while appRdy was low");
            assertFails++;
        end

    // One beat per burst
    wdfEndMatch: assert property (@(posedge MIGUICLK) disable iff (!resetn)
        appWdfEnd == appWdfWren)
        else begin
            $error("appWdfEnd differs from appWdfWren");
            assertFails++;
        end

    noEarlyCmd: assert property (@(posedge MIGUICLK) disable iff (!resetn)
        appEn |-> initCalibComplete)
        else begin
            $error("App command issued before calibration");
            assertFails++;
        end

endmodule

bind memController memControllerProps props (.*);

/* dv/scoreboard.sv */
`timescale 1ns/1ps

module scoreboard
    import memCtrlPkg::*;
(
    input logic                            MIGUICLK,
    input logic                            resetn,
    input logic                            rdAck,
    input logic [addrW-1:0]                rdAddr,
    input logic [blockCountW-1:0]          rdBlocks,
    input logic                            rdDone,
    input logic [addrW-1:0]                rdDoneAddr,
    input logic [taskWords-1:0][wordW-1:0] rdData,
    input logic                            wrAck,
    input logic [addrW-1:0]                wrAddr,
    input logic [blockCountW-1:0]          wrBlocks,
    input logic [taskWords-1:0][wordW-1:0] wrData,
    input logic                            wrDone,
    input logic                            appEn,
    input logic [2:0]                      appCmd,
    input logic [addrW-1:0]                appAddr,
    input logic                            appRdy,
    input logic [appDataW-1:0]             appWdfData,
    input logic                            appWdfWren,
    input logic                            appWdfRdy,
    input logic                            initCalibComplete
);

    logic [wordW-1:0] refMem [longint];
    readTaskT rdExp [$];
    writeTaskT wrExp [$];
    int dataErrors = 0;
    int flowErrors = 0;
    int rdAcks = 0;
    int rdDones = 0;
    int wrAcks = 0;
    int wrDones = 0;
    int cmdIdx = 0;
    int beatIdx = 0;
    logic rdAckPrev = 1'b0;
    logic wrAckPrev = 1'b0;
    logic wdfPrev = 1'b0;

    // Word k of a task lives in burst base + 8 * (k / 4)
    function automatic longint wordKey(input logic [addrW-1:0] base, input int k);
        logic [addrW-1:0] burst;
        burst = base + addrW'(addrStep * (k / wordsPerBeat));
        return longint'(burst) * wordsPerBeat + k % wordsPerBeat;
    endfunction

    //////////////////////////////
    task automatic checkCommand();
        logic [addrW-1:0] base;
        logic [addrW-1:0] expAddr;
        int blocks;
        if (appCmd == cmdRead && rdExp.size() > 0) begin
            base   = rdExp[0].addr;
            blocks = int'(rdExp[0].blocks);
        end else if (appCmd == cmdWrite && wrExp.size() > 0) begin
            base   = wrExp[0].addr;
            blocks = int'(wrExp[0].blocks);
        end else begin
            $display("App command %0h issued with no matching task outstanding", appCmd);
            flowErrors++;
            return;
        end
        expAddr = base + addrW'(addrStep * cmdIdx);
        if (appAddr !== expAddr) begin
            $display("CHECK FAILED appAddr: expected %h, got %h", expAddr, appAddr);
            dataErrors++;
        end
        cmdIdx = (cmdIdx + 1 >= blocks) ? 0 : cmdIdx + 1;
    endtask

    // Word 4j leads beat j on the bus
    task automatic checkBeat();
        logic [appDataW-1:0] expBeat;
        int firstWord;
        if (wrExp.size() == 0) begin
            $display("Write data beat sent with no write outstanding");
            flowErrors++;
            return;
        end
        firstWord = beatIdx * wordsPerBeat;
        expBeat = {wrExp[0].data[firstWord], wrExp[0].data[firstWord + 1],
                   wrExp[0].data[firstWord + 2], wrExp[0].data[firstWord + 3]};
        if (appWdfData !== expBeat) begin
            $display("CHECK FAILED appWdfData: expected %h, got %h", expBeat, appWdfData);
            dataErrors++;
        end
        beatIdx = (beatIdx + 1 >= int'(wrExp[0].blocks)) ? 0 : beatIdx + 1;
    endtask

    task automatic checkRead();
        readTaskT t;
        longint key;
        if (rdExp.size() == 0) begin
            $display("rdDone pulsed with no read outstanding");
            flowErrors++;
            return;
        end
        t = rdExp.pop_front();
        if (rdDoneAddr !== t.addr) begin
            $display("CHECK FAILED rdDoneAddr: expected %h, got %h", t.addr, rdDoneAddr);
            dataErrors++;
        end
        for (int k = 0; k < int'(t.blocks) * wordsPerBeat; k++) begin
            key = wordKey(t.addr, k);
            if (!refMem.exists(key)) begin
                $display("Read at %h word %0d hit memory that was never written", t.addr, k);
                flowErrors++;
            end else if (rdData[k] !== refMem[key]) begin
                $display("CHECK FAILED rdData[%0d]: expected %h, got %h",
                         k, refMem[key], rdData[k]);
                dataErrors++;
            end
        end
    endtask

    task automatic applyWrite();
        writeTaskT t;
        if (wrExp.size() == 0) begin
            $display("wrDone pulsed with no write outstanding");
            flowErrors++;
            return;
        end
        t = wrExp.pop_front();
        for (int k = 0; k < int'(t.blocks) * wordsPerBeat; k++) begin
            refMem[wordKey(t.addr, k)] = t.data[k];
        end
    endtask

    task automatic checkPending();
        if (rdExp.size() + wrExp.size() != 0) begin
            $display("%0d reads and %0d writes never saw a done pulse",
                     rdExp.size(), wrExp.size());
            flowErrors++;
        end
    endtask

    //////////////////////////////
    always @(posedge MIGUICLK) begin
        if (resetn) begin
            // Reads acked before a write was popped must finish first
            if (appWdfWren && !wdfPrev && rdDones != rdAcks) begin
                $display("Write data started with %0d earlier reads pending", rdAcks - rdDones);
                flowErrors++;
            end
            if (rdAck && !rdAckPrev) begin
                rdExp.push_back('{addr: rdAddr, blocks: rdBlocks});
                rdAcks++;
            end
            if (wrAck && !wrAckPrev) begin
                if (!initCalibComplete && wrAcks - wrDones >= 2**queueDepthW) begin
                    $display("Write ack given with a full queue before calibration");
                    flowErrors++;
                end
                wrExp.push_back('{addr: wrAddr, blocks: wrBlocks, data: wrData});
                wrAcks++;
            end
            if (appWdfWren && appWdfRdy) begin
                checkBeat();
            end
            if (appEn && appRdy) begin
                checkCommand();
            end
            if (rdDone) begin
                checkRead();
                rdDones++;
            end
            if (wrDone) begin
                applyWrite();
                wrDones++;
            end
            rdAckPrev = rdAck;
            wrAckPrev = wrAck;
            wdfPrev   = appWdfWren;
        end
    end

endmodule

/* dv/appModel.sv */
`timescale 1ns/1ps

module appModel
    import memCtrlPkg::*;
(
    input  logic                MIGUICLK,
    input  logic                resetn,
    input  logic                appEn,
    input  logic [2:0]          appCmd,
    input  logic [addrW-1:0]    appAddr,
    output logic                appRdy,
    input  logic [appDataW-1:0] appWdfData,
    input  logic                appWdfWren,
    output logic                appWdfRdy,
    output logic [appDataW-1:0] appRdData,
    output logic                appRdDataValid,
    output logic                initCalibComplete
);

    localparam int calibCycles = 120;

    logic [appDataW-1:0] mem [logic [addrW-1:0]];
    logic [appDataW-1:0] wdfFifo [$];
    logic [addrW-1:0] rdAddrQ [$];
    int rdDueQ [$];
    int cycle;
    int lastDue;
    int calibCount;

    // Unwritten bursts read back a pattern made from the address
    function automatic logic [appDataW-1:0] fillBeat(input logic [addrW-1:0] a);
        logic [appDataW-1:0] beat;
        for (int w = 0; w < wordsPerBeat; w++) begin
            beat[appDataW - 1 - w * wordW -: wordW] = {5'b10101, a} + 32'(w);
        end
        return beat;
    endfunction

    initial begin
        appRdy            = 1'b0;
        appWdfRdy         = 1'b0;
        appRdData         = '0;
        appRdDataValid    = 1'b0;
        initCalibComplete = 1'b0;
    end

    always @(posedge MIGUICLK) begin
        int due;
        if (!resetn) begin
            wdfFifo.delete();
            rdAddrQ.delete();
            rdDueQ.delete();
            cycle      = 0;
            lastDue    = 0;
            calibCount = 0;
            #1;
            appRdy            = 1'b0;
            appWdfRdy         = 1'b0;
            appRdDataValid    = 1'b0;
            initCalibComplete = 1'b0;
        end else begin
            if (appWdfWren && appWdfRdy) begin
                wdfFifo.push_back(appWdfData);
            end
            if (appEn && appRdy) begin
                if (appCmd == cmdWrite && wdfFifo.size() > 0) begin
                    mem[appAddr] = wdfFifo.pop_front();
                end else if (appCmd == cmdRead) begin
                    // Returns stay in command order
                    due = cycle + 1 + int'($urandom_range(2, 6));
                    if (due <= lastDue) begin
                        due = lastDue + 1;
                    end
                    lastDue = due;
                    rdAddrQ.push_back(appAddr);
                    rdDueQ.push_back(due);
                end
            end
            cycle++;
            #1;
            if (calibCount < calibCycles) begin
                calibCount++;
            end
            initCalibComplete = (calibCount >= calibCycles);
            appRdy    = ($urandom_range(0, 3) != 0);
            appWdfRdy = ($urandom_range(0, 3) != 0);
            if (rdDueQ.size() > 0 && rdDueQ[0] <= cycle) begin
                appRdData = mem.exists(rdAddrQ[0]) ? mem[rdAddrQ[0]] : fillBeat(rdAddrQ[0]);
                appRdDataValid = 1'b1;
                void'(rdAddrQ.pop_front());
                void'(rdDueQ.pop_front());
            end else begin
                appRdDataValid = 1'b0;
            end
        end
    end

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic MIGUICLK,
    output logic resetn
);

    initial begin
        MIGUICLK = 1'b0;
        forever #50 MIGUICLK = ~MIGUICLK;
    end

    // Reset held for 16 cycles
    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge MIGUICLK);
        #1 resetn = 1'b1;
    end

endmodule

/* logic/memController.sv */
`timescale 1ns/1ps

module memController
    import memCtrlPkg::*;
(
    input  logic                            MIGUICLK,
    input  logic                            resetn,
    // Client read side
    input  logic                            rdReq,
    input  logic [addrW-1:0]                rdAddr,
    input  logic [blockCountW-1:0]          rdBlocks,
    output logic                            rdAck,
    output logic                            rdDone,
    output logic [addrW-1:0]                rdDoneAddr,
    output logic [taskWords-1:0][wordW-1:0] rdData,
    // Client write side
    input  logic                            wrReq,
    input  logic [addrW-1:0]                wrAddr,
    input  logic [blockCountW-1:0]          wrBlocks,
    input  logic [taskWords-1:0][wordW-1:0] wrData,
    output logic                            wrAck,
    output logic                            wrDone,
    // App port
    output logic                            appEn,
    output logic [2:0]                      appCmd,
    output logic [addrW-1:0]                appAddr,
    input  logic                            appRdy,
    output logic [appDataW-1:0]             appWdfData,
    output logic                            appWdfWren,
    output logic                            appWdfEnd,
    input  logic                            appWdfRdy,
    input  logic [appDataW-1:0]             appRdData,
    input  logic                            appRdDataValid,
    input  logic                            initCalibComplete
);

    readTaskT  rdPayload, rdHead, readTask;
    writeTaskT wrPayload, wrHead, writeTask;
    logic rdNotEmpty, wrNotEmpty, rdPop, wrPop;
    logic readStart, writeStart, readComplete, beatsSent;

    assign rdPayload = '{addr: rdAddr, blocks: rdBlocks};
    assign wrPayload = '{addr: wrAddr, blocks: wrBlocks, data: wrData};

    //////////////////////////////
    taskQueue #(.payloadT(readTaskT)) rdQueue (
        .MIGUICLK(MIGUICLK), .resetn(resetn), .req(rdReq), .payload(rdPayload),
        .pop(rdPop), .ack(rdAck), .notEmpty(rdNotEmpty), .head(rdHead)
    );

    taskQueue #(.payloadT(writeTaskT)) wrQueue (
        .MIGUICLK(MIGUICLK), .resetn(resetn), .req(wrReq), .payload(wrPayload),
        .pop(wrPop), .ack(wrAck), .notEmpty(wrNotEmpty), .head(wrHead)
    );

    seqControl seq (
        .MIGUICLK(MIGUICLK), .resetn(resetn), .initCalibComplete(initCalibComplete),
        .rdNotEmpty(rdNotEmpty), .rdHead(rdHead), .wrNotEmpty(wrNotEmpty), .wrHead(wrHead),
        .appRdy(appRdy), .beatsSent(beatsSent), .readComplete(readComplete),
        .rdPop(rdPop), .wrPop(wrPop), .appEn(appEn), .appCmd(appCmd), .appAddr(appAddr),
        .writeStart(writeStart), .writeTask(writeTask), .readStart(readStart),
        .readTask(readTask), .wrDone(wrDone)
    );

    writeSerializer wrSer (
        .MIGUICLK(MIGUICLK), .resetn(resetn), .writeStart(writeStart),
        .writeTask(writeTask), .appWdfRdy(appWdfRdy), .appWdfData(appWdfData),
        .appWdfWren(appWdfWren), .appWdfEnd(appWdfEnd), .beatsSent(beatsSent)
    );

    readAssembler rdAsm (
        .MIGUICLK(MIGUICLK), .resetn(resetn), .readStart(readStart), .readTask(readTask),
        .appRdData(appRdData), .appRdDataValid(appRdDataValid),
        .readComplete(readComplete), .rdDone(rdDone), .rdDoneAddr(rdDoneAddr),
        .rdData(rdData)
    );

endmodule

/* logic/readAssembler.sv */
`timescale 1ns/1ps

module readAssembler
    import memCtrlPkg::*;
(
    input  logic                            MIGUICLK,
    input  logic                            resetn,
    input  logic                            readStart,
    input  readTaskT                        readTask,
    input  logic [appDataW-1:0]             appRdData,
    input  logic                            appRdDataValid,
    output logic                            readComplete,
    output logic                            rdDone,
    output logic [addrW-1:0]                rdDoneAddr,
    output logic [taskWords-1:0][wordW-1:0] rdData
);

    logic [addrW-1:0] addrReg;
    logic [blockCountW-1:0] blocksReg;
    logic [blockCountW-1:0] beatIdx;

    assign readComplete = appRdDataValid && (beatIdx == blocksReg - blockCountW'(1));

    always_ff @(posedge MIGUICLK or negedge resetn) begin
        if (!resetn) begin
            blocksReg <= '0;
            beatIdx   <= '0;
            rdDone    <= 1'b0;
        end else begin
            rdDone <= readComplete;
            if (readStart) begin
                blocksReg <= readTask.blocks;
                beatIdx   <= '0;
            end else if (appRdDataValid) begin
                beatIdx <= beatIdx + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Result words stay untouched past the block count
    always_ff @(posedge MIGUICLK) begin
        if (readStart) begin
            addrReg <= readTask.addr;
        end
        if (readComplete) begin
            rdDoneAddr <= addrReg;
        end
        if (appRdDataValid) begin
            for (int w = 0; w < wordsPerBeat; w++) begin
                rdData[int'(beatIdx) * wordsPerBeat + w] <=
                    appRdData[appDataW - 1 - w * wordW -: wordW];
            end
        end
    end

endmodule

/* logic/writeSerializer.sv */
`timescale 1ns/1ps

module writeSerializer
    import memCtrlPkg::*;
(
    input  logic                MIGUICLK,
    input  logic                resetn,
    input  logic                writeStart,
    input  writeTaskT           writeTask,
    input  logic                appWdfRdy,
    output logic [appDataW-1:0] appWdfData,
    output logic                appWdfWren,
    output logic                appWdfEnd,
    output logic                beatsSent
);

    writeTaskT taskReg;
    logic [blockCountW-1:0] beatIdx;

    // One beat per burst
    assign appWdfEnd = appWdfWren;

    // Lowest word of the beat in the top bits
    always_comb begin
        for (int w = 0; w < wordsPerBeat; w++) begin
            appWdfData[appDataW - 1 - w * wordW -: wordW] =
                taskReg.data[int'(beatIdx) * wordsPerBeat + w];
        end
    end

    always_ff @(posedge MIGUICLK or negedge resetn) begin
        if (!resetn) begin
            appWdfWren <= 1'b0;
            beatIdx    <= '0;
            beatsSent  <= 1'b0;
        end else begin
            beatsSent <= 1'b0;
            if (writeStart) begin
                appWdfWren <= 1'b1;
                beatIdx    <= '0;
            end else if (appWdfWren && appWdfRdy) begin
                if (beatIdx == taskReg.blocks - blockCountW'(1)) begin
                    appWdfWren <= 1'b0;
                    beatsSent  <= 1'b1;
                end else begin
                    beatIdx <= beatIdx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge MIGUICLK) begin
        if (writeStart) begin
            taskReg <= writeTask;
        end
    end

endmodule

/* logic/seqControl.sv */
`timescale 1ns/1ps

module seqControl
    import memCtrlPkg::*;
(
    input  logic             MIGUICLK,
    input  logic             resetn,
    input  logic             initCalibComplete,
    input  logic             rdNotEmpty,
    input  readTaskT         rdHead,
    input  logic             wrNotEmpty,
    input  writeTaskT        wrHead,
    input  logic             appRdy,
    input  logic             beatsSent,
    input  logic             readComplete,
    output logic             rdPop,
    output logic             wrPop,
    output logic             appEn,
    output logic [2:0]       appCmd,
    output logic [addrW-1:0] appAddr,
    output logic             writeStart,
    output writeTaskT        writeTask,
    output logic             readStart,
    output readTaskT         readTask,
    output logic             wrDone
);

    seqStateT state;
    logic [blockCountW-1:0] curBlocks;
    logic [blockCountW-1:0] cmdCount;
    logic cmdTaken;
    logic lastCmd;

    //////////////////////////////
    // Arbitration with reads first
    assign rdPop = (state == seqWait) && rdNotEmpty;
    assign wrPop = (state == seqWait) && !rdNotEmpty && wrNotEmpty;

    // Datapath blocks latch the popped head themselves
    assign readStart  = rdPop;
    assign readTask   = rdHead;
    assign writeStart = wrPop;
    assign writeTask  = wrHead;

    assign cmdTaken = appEn && appRdy;
    assign lastCmd  = (cmdCount == curBlocks - blockCountW'(1));

    //////////////////////////////
    always_ff @(posedge MIGUICLK or negedge resetn) begin
        if (!resetn) begin
            state     <= seqIdle;
            appEn     <= 1'b0;
            appCmd    <= cmdWrite;
            appAddr   <= '0;
            curBlocks <= '0;
            cmdCount  <= '0;
            wrDone    <= 1'b0;
        end else begin
            wrDone <= 1'b0;
            case (state)
                seqIdle: begin
                    if (initCalibComplete) begin
                        state <= seqWait;
                    end
                end

                seqWait: begin
                    cmdCount <= '0;
                    if (rdPop) begin
                        appEn     <= 1'b1;
                        appCmd    <= cmdRead;
                        appAddr   <= rdHead.addr;
                        curBlocks <= rdHead.blocks;
                        state     <= seqReadIssue;
                    end else if (wrPop) begin
                        // Address is parked until all beats are out
                        appCmd    <= cmdWrite;
                        appAddr   <= wrHead.addr;
                        curBlocks <= wrHead.blocks;
                        state     <= seqWriteData;
                    end
                end

                seqReadIssue: begin
                    if (cmdTaken) begin
                        if (lastCmd) begin
                            appEn <= 1'b0;
                            state <= seqReadDrain;
                        end else begin
                            cmdCount <= cmdCount + 1'b1;
                            appAddr  <= appAddr + addrW'(addrStep);
                        end
                    end
                end

                seqReadDrain: begin
                    if (readComplete) begin
                        state <= seqWait;
                    end
                end

                seqWriteData: begin
                    if (beatsSent) begin
                        appEn <= 1'b1;
                        state <= seqWriteCmd;
                    end
                end

                seqWriteCmd: begin
                    if (cmdTaken) begin
                        if (lastCmd) begin
                            appEn  <= 1'b0;
                            wrDone <= 1'b1;
                            state  <= seqWait;
                        end else begin
                            cmdCount <= cmdCount + 1'b1;
                            appAddr  <= appAddr + addrW'(addrStep);
                        end
                    end
                end

                default: begin
                    appEn <= 1'b0;
                    state <= seqIdle;
                end
            endcase
        end
    end

endmodule

/* logic/taskQueue.sv */
`timescale 1ns/1ps

module taskQueue
    import memCtrlPkg::*;
#(
    parameter type payloadT = readTaskT
) (
    input  logic    MIGUICLK,
    input  logic    resetn,
    input  logic    req,
    input  payloadT payload,
    input  logic    pop,
    output logic    ack,
    output logic    notEmpty,
    output payloadT head
);

    payloadT entries [2**queueDepthW];

    // Extra pointer bit tells full from empty
    logic [queueDepthW:0] wrPtr;
    logic [queueDepthW:0] rdPtr;
    logic full;
    logic push;

    assign full = (wrPtr[queueDepthW] != rdPtr[queueDepthW]) &&
                  (wrPtr[queueDepthW-1:0] == rdPtr[queueDepthW-1:0]);
    assign notEmpty = (wrPtr != rdPtr);
    assign push = req && !ack && !full;
    assign head = entries[rdPtr[queueDepthW-1:0]];

    always_ff @(posedge MIGUICLK or negedge resetn) begin
        if (!resetn) begin
            ack   <= 1'b0;
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            // Ack stays up until the client drops req
            if (push) begin
                ack   <= 1'b1;
                wrPtr <= wrPtr + 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge MIGUICLK) begin
        if (push) begin
            entries[wrPtr[queueDepthW-1:0]] <= payload;
        end
    end

endmodule

/* logic/memCtrlPkg.sv */
package memCtrlPkg;

    //////////////////////////////
    // App port geometry
    localparam int addrW        = 27;
    localparam int wordW        = 32;
    localparam int wordsPerBeat = 4;
    localparam int appDataW     = wordW * wordsPerBeat;

    // Task limits
    localparam int maxBlocks   = 4;
    localparam int blockCountW = 3;
    localparam int taskWords   = maxBlocks * wordsPerBeat;
    localparam int addrStep    = 8;
    localparam int queueDepthW = 3;

    // App command codes
    localparam logic [2:0] cmdRead  = 3'd1;
    localparam logic [2:0] cmdWrite = 3'd0;

    //////////////////////////////
    typedef struct packed {
        logic [addrW-1:0]       addr;
        logic [blockCountW-1:0] blocks;
    } readTaskT;

    // Word k of the task sits at data[k]
    typedef struct packed {
        logic [addrW-1:0]                addr;
        logic [blockCountW-1:0]          blocks;
        logic [taskWords-1:0][wordW-1:0] data;
    } writeTaskT;

    typedef enum logic [2:0] {
        seqIdle,
        seqWait,
        seqReadIssue,
        seqReadDrain,
        seqWriteData,
        seqWriteCmd
    } seqStateT;

endpackage
